// ==== logic/tlb_cfg.svh ====
// itlb configuration
// widths, JTLB size and the fixed segment bounds of the fetch translator

`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// joint TLB size
`define TLB_ENTRIES        16
`define TLB_IDX_W          4

// field widths
`define VPN2_W             19         // vaddr[31:13], one even/odd page pair
`define PFN_W              20
`define ASID_W             8

// segment bounds
`define KSEG0_BASE         32'h8000_0000
`define KSEG1_BASE         32'hA000_0000
`define KSEG2_BASE         32'hC000_0000   // first mapped address above kseg1

// cache attribute that means cacheable, noncoherent
`define CACHE_ATTR_CACHED  3'd3

`endif

// ==== logic/tlb_pkg.sv ====
// itlb types
// width typedefs for addresses and entry fields, plus the fetch
// exception code and the refill state of the fetch buffer

`include "tlb_cfg.svh"

package tlb_pkg;

    // addresses
    typedef logic [31:0]              vaddr_t;
    typedef logic [31:0]              paddr_t;

    // entry fields
    typedef logic [`VPN2_W-1:0]       vpn2_t;
    typedef logic [`PFN_W-1:0]        pfn_t;
    typedef logic [`ASID_W-1:0]       asid_t;
    typedef logic [2:0]               cattr_t;
    typedef logic [`TLB_IDX_W-1:0]    tlb_idx_t;

    // fetch side exception, no modify case on the instruction path
    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_REFILL  = 2'd1,
        EXC_INVALID = 2'd2
    } tlb_exc_t;

    // fetch buffer refill machine
    typedef enum logic {
        BUF_IDLE   = 1'b0,
        BUF_SEARCH = 1'b1
    } buf_state_t;

endpackage

// ==== logic/tlb_array.sv ====
// joint TLB storage
// register based entries with one write port and a parallel
// combinational search that returns the lowest matching index

`include "tlb_cfg.svh"

module tlb_array import tlb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tlb_we,
    input  tlb_idx_t  tlb_widx,
    input  vpn2_t     w_vpn2,
    input  asid_t     w_asid,
    input  logic      w_g,
    input  pfn_t      w_pfn0,
    input  pfn_t      w_pfn1,
    input  cattr_t    w_c0,
    input  cattr_t    w_c1,
    input  logic      w_v0,
    input  logic      w_v1,
    input  logic      w_d0,
    input  logic      w_d1,
    input  vpn2_t     search_vpn2,
    input  asid_t     asid,
    output logic      found,
    output pfn_t      s_pfn0,
    output pfn_t      s_pfn1,
    output cattr_t    s_c0,
    output cattr_t    s_c1,
    output logic      s_v0,
    output logic      s_v1,
    output logic      s_g
);

    localparam int PAGE_W = `PFN_W + 5;   // {pfn, c, v, d}

    vpn2_t               vpn2_q [`TLB_ENTRIES];
    asid_t               asid_q [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] g_q;
    logic [PAGE_W-1:0]   page0_q [`TLB_ENTRIES];
    logic [PAGE_W-1:0]   page1_q [`TLB_ENTRIES];

    logic [PAGE_W-1:0]   page0_sel;
    logic [PAGE_W-1:0]   page1_sel;
    logic                g_sel;

    // all entries come out of reset invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                vpn2_q[i]  <= '0;
                asid_q[i]  <= '0;
                g_q[i]     <= 1'b0;
                page0_q[i] <= '0;
                page1_q[i] <= '0;
            end
        end else if (tlb_we) begin
            vpn2_q[tlb_widx]  <= w_vpn2;
            asid_q[tlb_widx]  <= w_asid;
            g_q[tlb_widx]     <= w_g;
            page0_q[tlb_widx] <= {w_pfn0, w_c0, w_v0, w_d0};
            page1_q[tlb_widx] <= {w_pfn1, w_c1, w_v1, w_d1};
        end
    end

    // walk downwards so the lowest matching index is the one left selected
    always_comb begin
        found     = 1'b0;
        page0_sel = '0;
        page1_sel = '0;
        g_sel     = 1'b0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (vpn2_q[i] == search_vpn2 && (g_q[i] || asid_q[i] == asid)) begin
                found     = 1'b1;
                page0_sel = page0_q[i];
                page1_sel = page1_q[i];
                g_sel     = g_q[i];
            end
        end
    end

    // dirty bits stay behind, fetches never need them
    assign s_pfn0 = page0_sel[PAGE_W-1 -: `PFN_W];
    assign s_c0   = page0_sel[4:2];
    assign s_v0   = page0_sel[1];
    assign s_pfn1 = page1_sel[PAGE_W-1 -: `PFN_W];
    assign s_c1   = page1_sel[4:2];
    assign s_v1   = page1_sel[1];
    assign s_g    = g_sel;

endmodule

// ==== logic/segment_map.sv ====
// segment decode for fetch addresses
// flags the kseg0/kseg1 windows and strips their base to get
// the physical address without a TLB lookup

`include "tlb_cfg.svh"

module segment_map import tlb_pkg::*; (
    input  vaddr_t  vaddr,
    output logic    unmapped,
    output logic    uncached_seg,
    output paddr_t  seg_paddr
);

    logic in_kseg0;
    logic in_kseg1;

    assign in_kseg1 = (vaddr >= `KSEG1_BASE) && (vaddr < `KSEG2_BASE);
    assign in_kseg0 = (vaddr >= `KSEG0_BASE) && (vaddr < `KSEG1_BASE);

    assign unmapped     = in_kseg0 || in_kseg1;
    assign uncached_seg = in_kseg1;          // kseg1 never goes through the cache

    always_comb begin
        if (in_kseg1) begin
            seg_paddr = vaddr - `KSEG1_BASE;
        end else if (in_kseg0) begin
            seg_paddr = vaddr - `KSEG0_BASE;
        end else begin
            seg_paddr = vaddr;               // mapped, unused by the resolver
        end
    end

endmodule

// ==== logic/itlb_buffer.sv ====
// one entry fetch translation buffer
// hit check against the held entry, and a two state refill machine
// that searches the JTLB for one cycle after a mapped miss

module itlb_buffer import tlb_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  vaddr_t  vaddr,
    input  asid_t   asid,
    input  logic    unmapped,
    input  logic    buf_flush,
    input  logic    found,
    input  pfn_t    s_pfn0,
    input  pfn_t    s_pfn1,
    input  cattr_t  s_c0,
    input  cattr_t  s_c1,
    input  logic    s_v0,
    input  logic    s_v1,
    input  logic    s_g,
    output vpn2_t   search_vpn2,
    output logic    hit,
    output logic    b_found,
    output pfn_t    b_pfn0,
    output pfn_t    b_pfn1,
    output cattr_t  b_c0,
    output cattr_t  b_c1,
    output logic    b_v0,
    output logic    b_v1
);

    buf_state_t state_q;
    buf_state_t state_d;

    logic   valid_q;
    vpn2_t  vpn2_q;
    asid_t  asid_q;
    logic   g_q;
    logic   found_q;
    logic   refill;
    logic   entry_hit;

    assign search_vpn2 = vaddr[31:13];

    // the asid check is skipped for global pages
    assign entry_hit = valid_q && (vpn2_q == vaddr[31:13]) && (g_q || asid_q == asid);
    assign hit       = unmapped || entry_hit;

    always_comb begin
        case (state_q)
            BUF_IDLE:   state_d = hit ? BUF_IDLE : BUF_SEARCH;
            BUF_SEARCH: state_d = BUF_IDLE;  // search takes exactly one cycle
            default:    state_d = BUF_IDLE;
        endcase
    end

    assign refill = (state_q == BUF_SEARCH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BUF_IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (buf_flush) begin
                valid_q <= 1'b0;             // flush wins over a refill
            end else if (refill) begin
                valid_q <= 1'b1;             // also on a failed search
            end
        end
    end

    // entry payload, only meaningful while valid_q is set
    always_ff @(posedge clk) begin
        if (refill && !buf_flush) begin
            vpn2_q  <= vaddr[31:13];
            asid_q  <= asid;                 // equals the entry asid unless global
            g_q     <= s_g;
            found_q <= found;
            b_pfn0  <= s_pfn0;
            b_pfn1  <= s_pfn1;
            b_c0    <= s_c0;
            b_c1    <= s_c1;
            b_v0    <= s_v0;
            b_v1    <= s_v1;
        end
    end

    assign b_found = found_q;

endmodule

// ==== logic/itlb_resolve.sv ====
// fetch translation resolver
// merges the segment decode with the buffered entry into the
// physical address, cache flag, valid flag, stall and exception

`include "tlb_cfg.svh"

module itlb_resolve import tlb_pkg::*; (
    input  vaddr_t    vaddr,
    input  cattr_t    k0,
    input  logic      unmapped,
    input  logic      uncached_seg,
    input  paddr_t    seg_paddr,
    input  logic      hit,
    input  logic      b_found,
    input  pfn_t      b_pfn0,
    input  pfn_t      b_pfn1,
    input  cattr_t    b_c0,
    input  cattr_t    b_c1,
    input  logic      b_v0,
    input  logic      b_v1,
    output paddr_t    paddr,
    output logic      cached,
    output logic      fetch_valid,
    output logic      fetch_stall,
    output tlb_exc_t  fetch_exc
);

    pfn_t   sel_pfn;
    cattr_t sel_c;
    logic   sel_v;
    cattr_t attr;

    // vaddr[12] picks the odd or even page of the pair
    assign sel_pfn = vaddr[12] ? b_pfn1 : b_pfn0;
    assign sel_c   = vaddr[12] ? b_c1   : b_c0;
    assign sel_v   = vaddr[12] ? b_v1   : b_v0;

    assign paddr = unmapped ? seg_paddr : {sel_pfn, vaddr[11:0]};

    // kseg0 follows config K0, mapped pages follow their own C field
    assign attr   = unmapped ? k0 : sel_c;
    assign cached = !uncached_seg && (attr == `CACHE_ATTR_CACHED);

    assign fetch_stall = !hit;

    always_comb begin
        fetch_valid = 1'b0;
        fetch_exc   = EXC_NONE;
        if (unmapped) begin
            fetch_valid = 1'b1;
        end else if (!hit) begin
            // search still pending, exception not known yet
            fetch_valid = 1'b0;
            fetch_exc   = EXC_NONE;
        end else if (!b_found) begin
            fetch_exc   = EXC_REFILL;        // no JTLB entry for this page pair
        end else if (!sel_v) begin
            fetch_exc   = EXC_INVALID;
        end else begin
            fetch_valid = 1'b1;
        end
    end

endmodule

// ==== logic/itlb_top.sv ====
// instruction fetch address translation unit
// segment decode and the one entry buffer run side by side, the buffer
// refills from the JTLB array, the resolver builds the fetch outputs

module itlb_top import tlb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  vaddr_t    vaddr,
    input  asid_t     asid,
    input  cattr_t    k0,
    input  logic      buf_flush,
    input  logic      tlb_we,
    input  tlb_idx_t  tlb_widx,
    input  vpn2_t     w_vpn2,
    input  asid_t     w_asid,
    input  logic      w_g,
    input  pfn_t      w_pfn0,
    input  pfn_t      w_pfn1,
    input  cattr_t    w_c0,
    input  cattr_t    w_c1,
    input  logic      w_v0,
    input  logic      w_v1,
    input  logic      w_d0,
    input  logic      w_d1,
    output paddr_t    paddr,
    output logic      cached,
    output logic      fetch_valid,
    output logic      fetch_stall,
    output tlb_exc_t  fetch_exc
);

    // segment decode
    logic   unmapped;
    logic   uncached_seg;
    paddr_t seg_paddr;

    // JTLB search result
    vpn2_t  search_vpn2;
    logic   found;
    pfn_t   s_pfn0, s_pfn1;
    cattr_t s_c0, s_c1;
    logic   s_v0, s_v1, s_g;

    // buffered entry
    logic   hit;
    logic   b_found;
    pfn_t   b_pfn0, b_pfn1;
    cattr_t b_c0, b_c1;
    logic   b_v0, b_v1;

    tlb_array i_tlb_array (
        .clk(clk), .rst_n(rst_n),
        .tlb_we(tlb_we), .tlb_widx(tlb_widx),
        .w_vpn2(w_vpn2), .w_asid(w_asid), .w_g(w_g),
        .w_pfn0(w_pfn0), .w_pfn1(w_pfn1), .w_c0(w_c0), .w_c1(w_c1),
        .w_v0(w_v0), .w_v1(w_v1), .w_d0(w_d0), .w_d1(w_d1),
        .search_vpn2(search_vpn2), .asid(asid), .found(found),
        .s_pfn0(s_pfn0), .s_pfn1(s_pfn1), .s_c0(s_c0), .s_c1(s_c1),
        .s_v0(s_v0), .s_v1(s_v1), .s_g(s_g)
    );

    segment_map i_segment_map (
        .vaddr(vaddr), .unmapped(unmapped),
        .uncached_seg(uncached_seg), .seg_paddr(seg_paddr)
    );

    itlb_buffer i_itlb_buffer (
        .clk(clk), .rst_n(rst_n),
        .vaddr(vaddr), .asid(asid), .unmapped(unmapped), .buf_flush(buf_flush),
        .found(found), .s_pfn0(s_pfn0), .s_pfn1(s_pfn1), .s_c0(s_c0), .s_c1(s_c1),
        .s_v0(s_v0), .s_v1(s_v1), .s_g(s_g),
        .search_vpn2(search_vpn2), .hit(hit), .b_found(b_found),
        .b_pfn0(b_pfn0), .b_pfn1(b_pfn1), .b_c0(b_c0), .b_c1(b_c1),
        .b_v0(b_v0), .b_v1(b_v1)
    );

    itlb_resolve i_itlb_resolve (
        .vaddr(vaddr), .k0(k0),
        .unmapped(unmapped), .uncached_seg(uncached_seg), .seg_paddr(seg_paddr),
        .hit(hit), .b_found(b_found),
        .b_pfn0(b_pfn0), .b_pfn1(b_pfn1), .b_c0(b_c0), .b_c1(b_c1),
        .b_v0(b_v0), .b_v1(b_v1),
        .paddr(paddr), .cached(cached), .fetch_valid(fetch_valid),
        .fetch_stall(fetch_stall), .fetch_exc(fetch_exc)
    );

endmodule

// ==== testbench/itlb_chk.sv ====
// fetch translator protocol checks
// bound into itlb_top, watches the stall level and the exception code

`include "tlb_cfg.svh"

module itlb_chk import tlb_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input vaddr_t   vaddr,
    input logic     fetch_stall,
    input logic     fetch_valid,
    input tlb_exc_t fetch_exc
);

    timeunit 1ns;
    timeprecision 100ps;

    // kseg0 and kseg1 never wait on the buffer
    a_unmapped_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (vaddr >= `KSEG0_BASE && vaddr < `KSEG2_BASE) |-> !fetch_stall)
        else $error("stall on an unmapped fetch address");

    // a held miss resolves after two cycles of stall
    a_stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_stall && $past(fetch_stall) && $past(fetch_stall, 2)
          && vaddr == $past(vaddr) && vaddr == $past(vaddr, 2)))
        else $error("stall held longer than two cycles on the same address");

    a_no_exc_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_stall |-> fetch_exc == EXC_NONE)
        else $error("exception raised while the search is pending");

    a_valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_valid && fetch_exc != EXC_NONE))
        else $error("fetch_valid together with an exception");

endmodule

bind itlb_top itlb_chk i_itlb_chk (
    .clk(clk),
    .rst_n(rst_n),
    .vaddr(vaddr),
    .fetch_stall(fetch_stall),
    .fetch_valid(fetch_valid),
    .fetch_exc(fetch_exc)
);

// ==== testbench/itlb_tb.sv ====
// testbench for the fetch address translator
// applies a table of JTLB writes, buffer flushes and fetches, and checks
// address, cache flag, valid flag, exception and stall length of every fetch

module itlb_tb import tlb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STALL_LIMIT = 8;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_FLUSH,
        OP_FETCH
    } op_t;

    // write rows use vaddr as the page address and asid as the entry asid
    typedef struct packed {
        op_t      op;
        vaddr_t   vaddr;
        asid_t    asid;
        cattr_t   k0;
        tlb_idx_t idx;
        logic     g;
        pfn_t     pfn0;
        cattr_t   c0;
        logic     v0;
        pfn_t     pfn1;
        cattr_t   c1;
        logic     v1;
        paddr_t   exp_paddr;
        logic     exp_cached;
        logic     exp_valid;
        tlb_exc_t exp_exc;
        logic [3:0] exp_stall;    // stall cycles seen after the address is driven
    } row_t;

    logic     clk;
    logic     rst_n;
    vaddr_t   vaddr;
    asid_t    asid;
    cattr_t   k0;
    logic     buf_flush;
    logic     tlb_we;
    tlb_idx_t tlb_widx;
    vpn2_t    w_vpn2;
    asid_t    w_asid;
    logic     w_g;
    pfn_t     w_pfn0, w_pfn1;
    cattr_t   w_c0, w_c1;
    logic     w_v0, w_v1, w_d0, w_d1;
    paddr_t   paddr;
    logic     cached;
    logic     fetch_valid;
    logic     fetch_stall;
    tlb_exc_t fetch_exc;

    row_t  row_q[$];
    string name_q[$];

    itlb_top i_itlb_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    function automatic void add_fetch(string name, vaddr_t va, asid_t id, cattr_t k,
                                      paddr_t pa, logic c, logic v, tlb_exc_t exc,
                                      logic [3:0] stall);
        row_t r;
        r = '0;
        r.op         = OP_FETCH;
        r.vaddr      = va;
        r.asid       = id;
        r.k0         = k;
        r.exp_paddr  = pa;
        r.exp_cached = c;
        r.exp_valid  = v;
        r.exp_exc    = exc;
        r.exp_stall  = stall;
        row_q.push_back(r);
        name_q.push_back(name);
    endfunction

    function automatic void add_write(string name, tlb_idx_t idx, vaddr_t page, asid_t id,
                                      logic g, pfn_t p0, cattr_t c0, logic v0,
                                      pfn_t p1, cattr_t c1, logic v1);
        row_t r;
        r = '0;
        r.op    = OP_WRITE;
        r.idx   = idx;
        r.vaddr = page;
        r.asid  = id;
        r.g     = g;
        r.pfn0  = p0;
        r.c0    = c0;
        r.v0    = v0;
        r.pfn1  = p1;
        r.c1    = c1;
        r.v1    = v1;
        row_q.push_back(r);
        name_q.push_back(name);
    endfunction

    function automatic void add_flush(string name);
        row_t r;
        r = '0;
        r.op = OP_FLUSH;
        row_q.push_back(r);
        name_q.push_back(name);
    endfunction

    function automatic void build_table();
        // kseg1 and kseg0, k0 of 3 and 2
        add_fetch("kseg1_k3", 32'hbfc0_0100, 8'd0, 3'd3,
                  32'h1fc0_0100, 1'b0, 1'b1, EXC_NONE, 4'd0);
        add_fetch("kseg1_k2", 32'hbfc0_0100, 8'd0, 3'd2,
                  32'h1fc0_0100, 1'b0, 1'b1, EXC_NONE, 4'd0);
        add_fetch("kseg0_k3", 32'h8000_1234, 8'd0, 3'd3,
                  32'h0000_1234, 1'b1, 1'b1, EXC_NONE, 4'd0);
        add_fetch("kseg0_k2", 32'h9fff_fff0, 8'd0, 3'd2,
                  32'h1fff_fff0, 1'b0, 1'b1, EXC_NONE, 4'd0);
        add_fetch("kseg0_top", 32'h9fff_fff0, 8'd0, 3'd3,
                  32'h1fff_fff0, 1'b1, 1'b1, EXC_NONE, 4'd0);
        // private page pair under asid 5
        add_write("wr_pair", 4'd2, 32'h0040_0000, 8'd5, 1'b0,
                  20'h12345, 3'd3, 1'b1, 20'h0abcd, 3'd2, 1'b1);
        add_fetch("map_even", 32'h0040_0010, 8'd5, 3'd3,
                  32'h1234_5010, 1'b1, 1'b1, EXC_NONE, 4'd2);
        add_fetch("map_odd", 32'h0040_1ffc, 8'd5, 3'd3,
                  32'h0abc_dffc, 1'b0, 1'b1, EXC_NONE, 4'd0);
        // failed search leaves zero pfn and attribute
        add_fetch("no_entry", 32'h0080_0abc, 8'd5, 3'd3,
                  32'h0000_0abc, 1'b0, 1'b0, EXC_REFILL, 4'd2);
        add_write("wr_half", 4'd3, 32'h0100_0000, 8'd5, 1'b0,
                  20'h22222, 3'd3, 1'b0, 20'h33333, 3'd3, 1'b1);
        add_fetch("inv_even", 32'h0100_0040, 8'd5, 3'd3,
                  32'h2222_2040, 1'b1, 1'b0, EXC_INVALID, 4'd2);
        add_fetch("inv_odd", 32'h0100_1040, 8'd5, 3'd3,
                  32'h3333_3040, 1'b1, 1'b1, EXC_NONE, 4'd0);
        // asid switch on a buffered entry
        add_fetch("asid5_again", 32'h0040_0010, 8'd5, 3'd3,
                  32'h1234_5010, 1'b1, 1'b1, EXC_NONE, 4'd2);
        add_fetch("asid6_miss", 32'h0040_0010, 8'd6, 3'd3,
                  32'h0000_0010, 1'b0, 1'b0, EXC_REFILL, 4'd2);
        add_write("wr_global", 4'd4, 32'h0200_0000, 8'd9, 1'b1,
                  20'h44444, 3'd3, 1'b1, 20'h55555, 3'd2, 1'b1);
        add_fetch("global_a6", 32'h0200_0100, 8'd6, 3'd3,
                  32'h4444_4100, 1'b1, 1'b1, EXC_NONE, 4'd2);
        add_fetch("global_odd", 32'h0200_1100, 8'd6, 3'd3,
                  32'h5555_5100, 1'b0, 1'b1, EXC_NONE, 4'd0);
        // rewrite, buffer keeps the old pfn until flushed
        add_fetch("before_rw", 32'h0040_0010, 8'd5, 3'd3,
                  32'h1234_5010, 1'b1, 1'b1, EXC_NONE, 4'd2);
        add_write("wr_new_pfn", 4'd2, 32'h0040_0000, 8'd5, 1'b0,
                  20'h6789a, 3'd3, 1'b1, 20'h0abcd, 3'd2, 1'b1);
        add_fetch("stale_pfn", 32'h0040_0010, 8'd5, 3'd3,
                  32'h1234_5010, 1'b1, 1'b1, EXC_NONE, 4'd0);
        add_flush("flush");
        // the held address already missed in the cycle after the flush
        add_fetch("after_flush", 32'h0040_0010, 8'd5, 3'd3,
                  32'h6789_a010, 1'b1, 1'b1, EXC_NONE, 4'd1);
    endfunction

    task automatic compare(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", test, what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // outputs are sampled on the falling edge, well clear of the drive point
    task automatic wait_resolved(input string test, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (fetch_stall) begin
            if (cycles == STALL_LIMIT) begin
                $display("%s: fetch_stall never cleared within %0d cycles", test, STALL_LIMIT);
                $display("Some tests failed");
                $fatal(1, "stall timeout");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic write_entry(input row_t r);
        @(posedge clk);
        #1;
        tlb_we   = 1'b1;
        tlb_widx = r.idx;
        w_vpn2   = r.vaddr[31:13];
        w_asid   = r.asid;
        w_g      = r.g;
        w_pfn0   = r.pfn0;
        w_c0     = r.c0;
        w_v0     = r.v0;
        w_pfn1   = r.pfn1;
        w_c1     = r.c1;
        w_v1     = r.v1;
        @(posedge clk);
        #1;
        tlb_we = 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #1;
        buf_flush = 1'b1;
        @(posedge clk);
        #1;
        buf_flush = 1'b0;
    endtask

    task automatic fetch_and_check(input row_t r, input string test);
        int stall_cycles;
        @(posedge clk);
        #1;
        vaddr = r.vaddr;
        asid  = r.asid;
        k0    = r.k0;
        wait_resolved(test, stall_cycles);
        compare(test, "fetch_stall cycles", 32'(r.exp_stall), 32'(stall_cycles));
        compare(test, "paddr", r.exp_paddr, paddr);
        compare(test, "cached", 32'(r.exp_cached), 32'(cached));
        compare(test, "fetch_valid", 32'(r.exp_valid), 32'(fetch_valid));
        compare(test, "fetch_exc", 32'(r.exp_exc), 32'(fetch_exc));
    endtask

    initial begin
        rst_n     = 1'b0;
        vaddr     = 32'hbfc0_0000;  // unmapped, no stall during reset
        asid      = '0;
        k0        = 3'd3;
        buf_flush = 1'b0;
        tlb_we    = 1'b0;
        tlb_widx  = '0;
        w_vpn2    = '0;
        w_asid    = '0;
        w_g       = 1'b0;
        w_pfn0    = '0;
        w_pfn1    = '0;
        w_c0      = '0;
        w_c1      = '0;
        w_v0      = 1'b0;
        w_v1      = 1'b0;
        w_d0      = 1'b0;
        w_d1      = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (row_q[n]) begin
            case (row_q[n].op)
                OP_WRITE: write_entry(row_q[n]);
                OP_FLUSH: pulse_flush();
                OP_FETCH: fetch_and_check(row_q[n], name_q[n]);
                default:  ;
            endcase
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== itlb.f ====
+incdir+logic
logic/tlb_pkg.sv
logic/tlb_array.sv
logic/segment_map.sv
logic/itlb_buffer.sv
logic/itlb_resolve.sv
logic/itlb_top.sv
testbench/itlb_chk.sv
testbench/itlb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the itlb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module itlb_tb -Mdir obj_dir -o itlb_sim -f itlb.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/itlb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
